// File: src/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    // register file sizes
    parameter int S_REGS = 32;
    parameter int M_REGS = 16;

    // anything outside these major opcodes decodes as a no-op
    typedef enum logic [6:0] {
        OP_ALU    = 7'b0110011,
        OP_ALUI   = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_MLOAD  = 7'b0000111,
        OP_MSTORE = 7'b0100111,
        OP_GEMM   = 7'b1110111
    } opcode_t;

    // scalar functional units
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LD_ST  = 2'd1,
        FU_BRANCH = 2'd2,
        FU_NONE_S = 2'd3
    } fu_s_t;

    // matrix functional units
    typedef enum logic [1:0] {
        FU_NONE_M  = 2'd0,
        FU_LD_ST_M = 2'd1,
        FU_GEMM    = 2'd2
    } fu_m_t;

    // dispatch_unit encoding seen by issue
    localparam logic [2:0] DU_ALU   = 3'd0;
    localparam logic [2:0] DU_LDST  = 3'd1;
    localparam logic [2:0] DU_BR    = 3'd2;
    localparam logic [2:0] DU_MLDST = 3'd3;
    localparam logic [2:0] DU_GEMM  = 3'd4;
    localparam logic [2:0] DU_NONE  = 3'd5;

    // scalar view of the instruction word
    typedef struct packed {
        logic [6:0] fill_hi; // funct7 slot
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] fill_lo; // funct3 slot
        logic [4:0] rd;
        opcode_t    opcode;
    } instr_s_t;

    // matrix view reads its opcode through .s
    typedef struct packed {
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [3:0]  rs3;
        logic [15:0] imm;
    } instr_m_t;

    // one fetched word, two decodings
    typedef union packed {
        instr_s_t s;
        instr_m_t m;
    } instr_u;

endpackage

`default_nettype wire

// File: src/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  dispatch_pkg::instr_u instr,
    output dispatch_pkg::fu_s_t  fu_s,
    output dispatch_pkg::fu_m_t  fu_m,
    output logic                 s_write,
    output logic                 m_write,
    output logic                 tag_load
);

    always_comb begin
        // default is a no-op
        fu_s    = dispatch_pkg::FU_NONE_S;
        fu_m    = dispatch_pkg::FU_NONE_M;
        s_write = 1'b0;
        m_write = 1'b0;

        case (instr.s.opcode)
            dispatch_pkg::OP_ALU: begin
                fu_s    = dispatch_pkg::FU_ALU;
                s_write = 1'b1;
            end
            dispatch_pkg::OP_ALUI: begin
                fu_s    = dispatch_pkg::FU_ALU;
                s_write = 1'b1;
            end
            dispatch_pkg::OP_LOAD: begin
                fu_s    = dispatch_pkg::FU_LD_ST;
                s_write = 1'b1;
            end
            dispatch_pkg::OP_STORE: begin
                fu_s = dispatch_pkg::FU_LD_ST; // address only
            end
            dispatch_pkg::OP_BRANCH: begin
                fu_s = dispatch_pkg::FU_BRANCH;
            end
            dispatch_pkg::OP_MLOAD: begin
                fu_m    = dispatch_pkg::FU_LD_ST_M;
                m_write = 1'b1;
            end
            dispatch_pkg::OP_MSTORE: begin
                fu_m = dispatch_pkg::FU_LD_ST_M;
            end
            dispatch_pkg::OP_GEMM: begin
                fu_m    = dispatch_pkg::FU_GEMM;
                m_write = 1'b1;
            end
            default: ;
        endcase
    end

    // tag is 1 for the load units and 0 for alu/gemm
    always_comb begin
        tag_load = (fu_s == dispatch_pkg::FU_LD_ST) |
                   (fu_m == dispatch_pkg::FU_LD_ST_M);
    end

endmodule

`default_nettype wire

// File: src/reg_status_table.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status_table #(
    parameter int NREGS = dispatch_pkg::S_REGS
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     set_en,
    input  logic [$clog2(NREGS)-1:0] set_sel,
    input  logic                     set_tag,
    input  logic                     clr_en,
    input  logic [$clog2(NREGS)-1:0] clr_sel,
    output logic [NREGS-1:0]         busy,
    output logic [NREGS-1:0]         tag
);

    // one busy bit and one producer tag per register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
            tag  <= '0;
        end else begin
            // writeback commit frees the entry
            if (clr_en) begin
                busy[clr_sel] <= 1'b0;
            end
            // dispatch set comes last so it wins a same-register collision
            if (set_en) begin
                busy[set_sel] <= 1'b1;
                tag[set_sel]  <= set_tag;
            end
        end
    end

    // writeback only commits registers that dispatch marked as in flight
    assert property (@(posedge CLK) disable iff (!nRST)
        clr_en |-> busy[clr_sel])
        else $error("writeback clear of idle register %0d", clr_sel);

endmodule

`default_nettype wire

// File: src/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage #(
    parameter int S_NREGS = dispatch_pkg::S_REGS,
    parameter int M_NREGS = dispatch_pkg::M_REGS
) (
    input  logic                       CLK,
    input  logic                       nRST,
    input  dispatch_pkg::instr_u       instr,
    input  logic                       ihit,
    input  logic                       freeze,
    input  logic                       flush,
    input  logic                       fu_alu_busy,
    input  logic                       fu_ldst_busy,
    input  logic                       fu_branch_busy,
    input  logic                       fu_mldst_busy,
    input  logic                       fu_gemm_busy,
    input  dispatch_pkg::fu_s_t        fu_s,
    input  dispatch_pkg::fu_m_t        fu_m,
    input  logic                       s_write,
    input  logic                       m_write,
    input  logic                       tag_load,
    input  logic [S_NREGS-1:0]         s_busy,
    input  logic [S_NREGS-1:0]         s_tag,
    input  logic [M_NREGS-1:0]         m_busy,
    input  logic [M_NREGS-1:0]         m_tag,
    output logic                       s_set_en,
    output logic [$clog2(S_NREGS)-1:0] s_set_sel,
    output logic                       s_set_tag,
    output logic                       m_set_en,
    output logic [$clog2(M_NREGS)-1:0] m_set_sel,
    output logic                       m_set_tag,
    output logic                       stall,
    output logic                       dispatch_valid,
    output logic [2:0]                 dispatch_unit,
    output logic [4:0]                 dispatch_rd,
    output logic [4:0]                 dispatch_rs1,
    output logic [4:0]                 dispatch_rs2,
    output logic [4:0]                 dispatch_rs3,
    output logic                       dispatch_p1,
    output logic                       dispatch_p2,
    output logic                       dispatch_p3,
    output logic                       dispatch_t1,
    output logic                       dispatch_t2,
    output logic                       dispatch_t3
);

    localparam int S_W = $clog2(S_NREGS);
    localparam int M_W = $clog2(M_NREGS);

    logic       struct_haz;
    logic       waw;
    logic       hazard;
    logic       accept;
    logic [2:0] n_unit;
    logic [4:0] n_rd, n_rs1, n_rs2, n_rs3;
    logic       n_p1, n_p2, n_p3;
    logic       n_t1, n_t2, n_t3;

    // busy level of whichever unit the opcode selected
    always_comb begin
        struct_haz = 1'b0;
        case (fu_s)
            dispatch_pkg::FU_ALU:    struct_haz = fu_alu_busy;
            dispatch_pkg::FU_LD_ST:  struct_haz = fu_ldst_busy;
            dispatch_pkg::FU_BRANCH: struct_haz = fu_branch_busy;
            default:                 struct_haz = 1'b0;
        endcase
        case (fu_m)
            dispatch_pkg::FU_LD_ST_M: struct_haz = struct_haz | fu_mldst_busy;
            dispatch_pkg::FU_GEMM:    struct_haz = struct_haz | fu_gemm_busy;
            default:                  struct_haz = struct_haz;
        endcase
    end

    // matrix writer checks the matrix table first
    assign waw = m_write ? m_busy[instr.m.rd] :
                 s_write ? s_busy[instr.s.rd] : 1'b0;

    assign hazard = struct_haz | waw;
    assign accept = ihit & ~hazard & ~freeze & ~flush;
    assign stall  = ihit & hazard & ~flush;

    // table sets only for instructions that move forward
    assign s_set_en  = accept & s_write;
    assign s_set_sel = S_W'(instr.s.rd);
    assign s_set_tag = tag_load;
    assign m_set_en  = accept & m_write;
    assign m_set_sel = M_W'(instr.m.rd);
    assign m_set_tag = tag_load;

    // next dispatch record with pending/tag taken before the edge
    always_comb begin
        n_unit = dispatch_pkg::DU_NONE;
        n_rd   = '0;
        n_rs1  = '0;
        n_rs2  = '0;
        n_rs3  = '0;
        n_p1   = 1'b0;
        n_p2   = 1'b0;
        n_p3   = 1'b0;
        n_t1   = 1'b0;
        n_t2   = 1'b0;
        n_t3   = 1'b0;

        if (fu_m == dispatch_pkg::FU_GEMM) begin
            n_unit = dispatch_pkg::DU_GEMM;
            n_rd   = {1'b0, instr.m.rd};
            n_rs1  = {1'b0, instr.m.rs1};
            n_rs2  = {1'b0, instr.m.rs2};
            n_rs3  = {1'b0, instr.m.rs3};
            n_p1   = m_busy[instr.m.rs1];
            n_p2   = m_busy[instr.m.rs2];
            n_p3   = m_busy[instr.m.rs3];
            n_t1   = m_tag[instr.m.rs1];
            n_t2   = m_tag[instr.m.rs2];
            n_t3   = m_tag[instr.m.rs3];
        end else if (fu_m == dispatch_pkg::FU_LD_ST_M) begin
            n_unit = dispatch_pkg::DU_MLDST;
            n_rd   = {1'b0, instr.m.rd};
            n_rs1  = instr.s.rs1; // scalar base address
            n_p1   = s_busy[instr.s.rs1];
            n_t1   = s_tag[instr.s.rs1];
        end else if (fu_s != dispatch_pkg::FU_NONE_S) begin
            case (fu_s)
                dispatch_pkg::FU_ALU:   n_unit = dispatch_pkg::DU_ALU;
                dispatch_pkg::FU_LD_ST: n_unit = dispatch_pkg::DU_LDST;
                default:                n_unit = dispatch_pkg::DU_BR;
            endcase
            n_rd  = instr.s.rd;
            n_rs1 = instr.s.rs1;
            n_rs2 = instr.s.rs2;
            n_p1  = s_busy[instr.s.rs1];
            n_p2  = s_busy[instr.s.rs2];
            n_t1  = s_tag[instr.s.rs1];
            n_t2  = s_tag[instr.s.rs2];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dispatch_valid <= 1'b0;
            dispatch_unit  <= dispatch_pkg::DU_NONE;
            dispatch_rd    <= '0;
            dispatch_rs1   <= '0;
            dispatch_rs2   <= '0;
            dispatch_rs3   <= '0;
            {dispatch_p1, dispatch_p2, dispatch_p3} <= '0;
            {dispatch_t1, dispatch_t2, dispatch_t3} <= '0;
        end else if (flush && ihit) begin
            dispatch_valid <= 1'b0;
            dispatch_unit  <= dispatch_pkg::DU_NONE;
            dispatch_rd    <= '0;
            dispatch_rs1   <= '0;
            dispatch_rs2   <= '0;
            dispatch_rs3   <= '0;
            {dispatch_p1, dispatch_p2, dispatch_p3} <= '0;
            {dispatch_t1, dispatch_t2, dispatch_t3} <= '0;
        end else if (freeze || hazard) begin
            dispatch_valid <= dispatch_valid; // keep presenting to issue
        end else if (ihit) begin
            dispatch_valid <= 1'b1;
            dispatch_unit  <= n_unit;
            dispatch_rd    <= n_rd;
            dispatch_rs1   <= n_rs1;
            dispatch_rs2   <= n_rs2;
            dispatch_rs3   <= n_rs3;
            {dispatch_p1, dispatch_p2, dispatch_p3} <= {n_p1, n_p2, n_p3};
            {dispatch_t1, dispatch_t2, dispatch_t3} <= {n_t1, n_t2, n_t3};
        end
    end

    // decoder never flags both register classes as written
    assert property (@(posedge CLK) disable iff (!nRST)
        !(s_set_en && m_set_en))
        else $error("scalar and matrix table set in the same cycle");

    // back-pressure never lets a new record through
    assert property (@(posedge CLK) disable iff (!nRST)
        freeze |=> !$rose(dispatch_valid))
        else $error("dispatch_valid rose under freeze");

endmodule

`default_nettype wire

// File: src/dispatch_top.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_top #(
    parameter int S_NREGS = dispatch_pkg::S_REGS,
    parameter int M_NREGS = dispatch_pkg::M_REGS
) (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic [31:0]                instr,
    input  logic                       ihit,
    input  logic                       freeze,
    input  logic                       flush,
    input  logic                       fu_alu_busy,
    input  logic                       fu_ldst_busy,
    input  logic                       fu_branch_busy,
    input  logic                       fu_mldst_busy,
    input  logic                       fu_gemm_busy,
    input  logic                       wb_s_en,
    input  logic [$clog2(S_NREGS)-1:0] wb_s_sel,
    input  logic                       wb_m_en,
    input  logic [$clog2(M_NREGS)-1:0] wb_m_sel,
    output logic                       stall,
    output logic                       dispatch_valid,
    output logic [2:0]                 dispatch_unit,
    output logic [4:0]                 dispatch_rd,
    output logic [4:0]                 dispatch_rs1,
    output logic [4:0]                 dispatch_rs2,
    output logic [4:0]                 dispatch_rs3,
    output logic                       dispatch_p1,
    output logic                       dispatch_p2,
    output logic                       dispatch_p3,
    output logic                       dispatch_t1,
    output logic                       dispatch_t2,
    output logic                       dispatch_t3
);

    dispatch_pkg::instr_u      instr_w;
    dispatch_pkg::fu_s_t       fu_s;
    dispatch_pkg::fu_m_t       fu_m;
    logic                      s_write, m_write, tag_load;
    logic [S_NREGS-1:0]        s_busy, s_tag;
    logic [M_NREGS-1:0]        m_busy, m_tag;
    logic                      s_set_en, s_set_tag;
    logic                      m_set_en, m_set_tag;
    logic [$clog2(S_NREGS)-1:0] s_set_sel;
    logic [$clog2(M_NREGS)-1:0] m_set_sel;

    assign instr_w = instr;

    instr_decoder dec (
        .instr    (instr_w),
        .fu_s     (fu_s),
        .fu_m     (fu_m),
        .s_write  (s_write),
        .m_write  (m_write),
        .tag_load (tag_load)
    );

    reg_status_table #(.NREGS(S_NREGS)) s_rst (
        .CLK     (CLK),
        .nRST    (nRST),
        .set_en  (s_set_en),
        .set_sel (s_set_sel),
        .set_tag (s_set_tag),
        .clr_en  (wb_s_en),
        .clr_sel (wb_s_sel),
        .busy    (s_busy),
        .tag     (s_tag)
    );

    reg_status_table #(.NREGS(M_NREGS)) m_rst (
        .CLK     (CLK),
        .nRST    (nRST),
        .set_en  (m_set_en),
        .set_sel (m_set_sel),
        .set_tag (m_set_tag),
        .clr_en  (wb_m_en),
        .clr_sel (wb_m_sel),
        .busy    (m_busy),
        .tag     (m_tag)
    );

    dispatch_stage #(.S_NREGS(S_NREGS), .M_NREGS(M_NREGS)) stage (
        .CLK            (CLK),
        .nRST           (nRST),
        .instr          (instr_w),
        .ihit           (ihit),
        .freeze         (freeze),
        .flush          (flush),
        .fu_alu_busy    (fu_alu_busy),
        .fu_ldst_busy   (fu_ldst_busy),
        .fu_branch_busy (fu_branch_busy),
        .fu_mldst_busy  (fu_mldst_busy),
        .fu_gemm_busy   (fu_gemm_busy),
        .fu_s           (fu_s),
        .fu_m           (fu_m),
        .s_write        (s_write),
        .m_write        (m_write),
        .tag_load       (tag_load),
        .s_busy         (s_busy),
        .s_tag          (s_tag),
        .m_busy         (m_busy),
        .m_tag          (m_tag),
        .s_set_en       (s_set_en),
        .s_set_sel      (s_set_sel),
        .s_set_tag      (s_set_tag),
        .m_set_en       (m_set_en),
        .m_set_sel      (m_set_sel),
        .m_set_tag      (m_set_tag),
        .stall          (stall),
        .dispatch_valid (dispatch_valid),
        .dispatch_unit  (dispatch_unit),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_rs3   (dispatch_rs3),
        .dispatch_p1    (dispatch_p1),
        .dispatch_p2    (dispatch_p2),
        .dispatch_p3    (dispatch_p3),
        .dispatch_t1    (dispatch_t1),
        .dispatch_t2    (dispatch_t2),
        .dispatch_t3    (dispatch_t3)
    );

endmodule

`default_nettype wire

// File: tests/dispatch_model.svh
`ifndef DISPATCH_MODEL_SVH
`define DISPATCH_MODEL_SVH

// mirror of both status tables and the dispatch record
logic [dispatch_pkg::S_REGS-1:0] sb_busy, sb_tag;
logic [dispatch_pkg::M_REGS-1:0] mb_busy, mb_tag;
logic       rec_valid;
logic [2:0] rec_unit;
logic [4:0] rec_rd, rec_rs1, rec_rs2, rec_rs3;
logic [2:0] rec_p, rec_t; // {src1, src2, src3}
logic       exp_stall;

task automatic reset_model();
    {sb_busy, sb_tag, mb_busy, mb_tag} = '0;
    rec_valid = 1'b0;
    rec_unit  = dispatch_pkg::DU_NONE;
    {rec_rd, rec_rs1, rec_rs2, rec_rs3, rec_p, rec_t} = '0;
    exp_stall = 1'b0;
endtask

// one clock edge worth of dispatch, from the inputs now on the pins
task automatic step_model();
    logic [4:0] srd, srs1, srs2;
    logic [3:0] mrd, mrs1, mrs2, mrs3;
    logic [2:0] unit;
    logic       sw, mw, ld, fb, haz, acc;

    srd  = instr[11:7];
    srs1 = instr[19:15];
    srs2 = instr[24:20];
    {mrd, mrs1, mrs2, mrs3} = instr[31:16];
    {sw, mw, ld, fb} = 4'b0000;
    unit = dispatch_pkg::DU_NONE;
    case (instr[6:0])
        dispatch_pkg::OP_ALU, dispatch_pkg::OP_ALUI: begin
            {unit, sw, fb} = {dispatch_pkg::DU_ALU, 1'b1, fu_alu_busy};
        end
        dispatch_pkg::OP_LOAD: begin
            {unit, sw, ld, fb} = {dispatch_pkg::DU_LDST, 2'b11, fu_ldst_busy};
        end
        dispatch_pkg::OP_STORE:  {unit, fb} = {dispatch_pkg::DU_LDST, fu_ldst_busy};
        dispatch_pkg::OP_BRANCH: {unit, fb} = {dispatch_pkg::DU_BR, fu_branch_busy};
        dispatch_pkg::OP_MLOAD: begin
            {unit, mw, ld, fb} = {dispatch_pkg::DU_MLDST, 2'b11, fu_mldst_busy};
        end
        dispatch_pkg::OP_MSTORE: {unit, fb} = {dispatch_pkg::DU_MLDST, fu_mldst_busy};
        dispatch_pkg::OP_GEMM: begin
            {unit, mw, fb} = {dispatch_pkg::DU_GEMM, 1'b1, fu_gemm_busy};
        end
        default: ; // no-op
    endcase

    haz = fb | (mw ? mb_busy[mrd] : (sw & sb_busy[srd]));
    exp_stall = ihit & haz & ~flush;
    acc = ihit & ~haz & ~freeze & ~flush;

    // record first so sources see the tables before the edge
    if (flush && ihit) begin
        rec_valid = 1'b0;
        rec_unit  = dispatch_pkg::DU_NONE;
        {rec_rd, rec_rs1, rec_rs2, rec_rs3, rec_p, rec_t} = '0;
    end else if (!freeze && !haz && ihit) begin
        rec_valid = 1'b1;
        rec_unit  = unit;
        {rec_rd, rec_rs1, rec_rs2, rec_rs3, rec_p, rec_t} = '0;
        if (unit == dispatch_pkg::DU_GEMM) begin
            {rec_rd, rec_rs1} = {1'b0, mrd, 1'b0, mrs1};
            {rec_rs2, rec_rs3} = {1'b0, mrs2, 1'b0, mrs3};
            rec_p = {mb_busy[mrs1], mb_busy[mrs2], mb_busy[mrs3]};
            rec_t = {mb_tag[mrs1], mb_tag[mrs2], mb_tag[mrs3]};
        end else if (unit == dispatch_pkg::DU_MLDST) begin
            {rec_rd, rec_rs1} = {1'b0, mrd, srs1}; // scalar base
            rec_p = {sb_busy[srs1], 2'b00};
            rec_t = {sb_tag[srs1], 2'b00};
        end else if (unit != dispatch_pkg::DU_NONE) begin
            {rec_rd, rec_rs1, rec_rs2} = {srd, srs1, srs2};
            rec_p = {sb_busy[srs1], sb_busy[srs2], 1'b0};
            rec_t = {sb_tag[srs1], sb_tag[srs2], 1'b0};
        end
    end

    // clear then set so set wins on the same register
    if (wb_s_en) sb_busy[wb_s_sel] = 1'b0;
    if (wb_m_en) mb_busy[wb_m_sel] = 1'b0;
    if (acc && sw) {sb_busy[srd], sb_tag[srd]} = {1'b1, ld};
    if (acc && mw) {mb_busy[mrd], mb_tag[mrd]} = {1'b1, ld};
endtask

task automatic check_record();
    checks++;
    if ({dispatch_valid, dispatch_unit, dispatch_rd, dispatch_rs1, dispatch_rs2, dispatch_rs3,
         dispatch_p1, dispatch_p2, dispatch_p3, dispatch_t1, dispatch_t2, dispatch_t3} !==
        {rec_valid, rec_unit, rec_rd, rec_rs1, rec_rs2, rec_rs3, rec_p, rec_t}) begin
        err_count++;
        $display("MISMATCH %0t: record got v=%b u=%0d rd=%0d rs=%0d/%0d/%0d p=%b%b%b t=%b%b%b",
                 $time, dispatch_valid, dispatch_unit, dispatch_rd, dispatch_rs1, dispatch_rs2,
                 dispatch_rs3, dispatch_p1, dispatch_p2, dispatch_p3,
                 dispatch_t1, dispatch_t2, dispatch_t3);
        $display("MISMATCH %0t: record exp v=%b u=%0d rd=%0d rs=%0d/%0d/%0d p=%b t=%b",
                 $time, rec_valid, rec_unit, rec_rd, rec_rs1, rec_rs2, rec_rs3, rec_p, rec_t);
    end
endtask

task automatic check_stall(input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
        err_count++;
        $display("MISMATCH %0t: stall exp %b got %b", $time, exp, got);
    end
endtask

task automatic check_busy(input logic [dispatch_pkg::S_REGS-1:0] exp_s, got_s,
                          input logic [dispatch_pkg::M_REGS-1:0] exp_m, got_m);
    checks++;
    if (got_s !== exp_s || got_m !== exp_m) begin
        err_count++;
        $display("MISMATCH %0t: busy exp s=%h m=%h got s=%h m=%h",
                 $time, exp_s, exp_m, got_s, got_m);
    end
endtask

`endif

// File: tests/dispatch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = 400;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + 5 * TEST_CYCLES; // five random phases
    localparam int SW = $clog2(dispatch_pkg::S_REGS);
    localparam int MW = $clog2(dispatch_pkg::M_REGS);

    logic          CLK, nRST;
    logic [31:0]   instr;
    logic          ihit, freeze, flush;
    logic          fu_alu_busy, fu_ldst_busy, fu_branch_busy, fu_mldst_busy, fu_gemm_busy;
    logic          wb_s_en, wb_m_en;
    logic [SW-1:0] wb_s_sel;
    logic [MW-1:0] wb_m_sel;
    logic          stall, dispatch_valid;
    logic [2:0]    dispatch_unit;
    logic [4:0]    dispatch_rd, dispatch_rs1, dispatch_rs2, dispatch_rs3;
    logic          dispatch_p1, dispatch_p2, dispatch_p3;
    logic          dispatch_t1, dispatch_t2, dispatch_t3;

    int         seed;
    int         checks, err_count;
    int         k_busy, k_freeze, k_flush, k_wb; // percent
    logic [4:0] rd_mask;

    `include "dispatch_model.svh"

    dispatch_top dut (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic int roll(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic chance(input int pct);
        return roll(100) < pct;
    endfunction

    task automatic drive_random();
        logic [31:0] w;
        int          s_q[$];
        int          m_q[$];

        w = $random(seed);
        case (roll(10))
            0: w[6:0] = dispatch_pkg::OP_ALU;
            1: w[6:0] = dispatch_pkg::OP_ALUI;
            2: w[6:0] = dispatch_pkg::OP_LOAD;
            3: w[6:0] = dispatch_pkg::OP_STORE;
            4: w[6:0] = dispatch_pkg::OP_BRANCH;
            5: w[6:0] = dispatch_pkg::OP_MLOAD;
            6: w[6:0] = dispatch_pkg::OP_MSTORE;
            7: w[6:0] = dispatch_pkg::OP_GEMM;
            default: ; // raw bits give mostly unknown opcodes
        endcase
        // squeeze register numbers to force collisions
        w[11:7]  = w[11:7] & rd_mask;
        w[19:15] = w[19:15] & rd_mask;
        w[31:24] = w[31:24] & {rd_mask[3:0], rd_mask[3:0]};
        instr          <= w;
        ihit           <= chance(85);
        freeze         <= chance(k_freeze);
        flush          <= chance(k_flush);
        fu_alu_busy    <= chance(k_busy);
        fu_ldst_busy   <= chance(k_busy);
        fu_branch_busy <= chance(k_busy);
        fu_mldst_busy  <= chance(k_busy);
        fu_gemm_busy   <= chance(k_busy);

        // writeback only commits what the model holds in flight
        for (int i = 0; i < dispatch_pkg::S_REGS; i++) if (sb_busy[i]) s_q.push_back(i);
        for (int i = 0; i < dispatch_pkg::M_REGS; i++) if (mb_busy[i]) m_q.push_back(i);
        wb_s_en  <= (s_q.size() > 0) && chance(k_wb);
        wb_s_sel <= (s_q.size() > 0) ? SW'(s_q[roll(s_q.size())]) : '0;
        wb_m_en  <= (m_q.size() > 0) && chance(k_wb);
        wb_m_sel <= (m_q.size() > 0) ? MW'(m_q[roll(m_q.size())]) : '0;
    endtask

    // compare state after the last edge, then advance the model
    task automatic sample_and_step();
        check_record();
        check_busy(sb_busy, dut.s_rst.busy, mb_busy, dut.m_rst.busy);
        step_model();
        check_stall(exp_stall, stall);
    endtask

    task automatic run_test(input string name, input int busy, input int frz, input int fl,
                            input int wb, input logic [4:0] mask);
        int errs_before;

        errs_before = err_count;
        {k_busy, k_freeze, k_flush, k_wb} = {busy, frz, fl, wb};
        rd_mask = mask;
        repeat (TEST_CYCLES) begin
            @(posedge CLK);
            drive_random();
            @(negedge CLK);
            sample_and_step();
        end
        $display("%-14s %0d cycles, %0d errors", name, TEST_CYCLES, err_count - errs_before);
    endtask

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        instr = '0;
        {ihit, freeze, flush} = '0;
        {fu_alu_busy, fu_ldst_busy, fu_branch_busy, fu_mldst_busy, fu_gemm_busy} = '0;
        {wb_s_en, wb_s_sel, wb_m_en, wb_m_sel} = '0;
        seed = 32'hc60c_b2b1;
        checks = 0;
        err_count = 0;
        reset_model();

        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        sample_and_step();
        $display("%-14s %0d errors", "reset", err_count);

        run_test("decode", 0, 0, 0, 70, 5'h1f);
        run_test("structural", 30, 0, 0, 60, 5'h1f);
        run_test("waw", 0, 0, 0, 30, 5'h03);
        run_test("sources", 10, 0, 0, 50, 5'h07);
        run_test("freeze_flush", 10, 25, 15, 50, 5'h07);

        $display("checks %0d, errors %0d", checks, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (TOTAL_CYCLES + 100));
        $display("watchdog expired after %0d cycles, run did not finish", TOTAL_CYCLES + 100);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+tests
src/dispatch_pkg.sv
src/instr_decoder.sv
src/reg_status_table.sv
src/dispatch_stage.sv
src/dispatch_top.sv
tests/dispatch_tb.sv

// File: Bender.yml
package:
  name: dispatch_stage

sources:
  - src/dispatch_pkg.sv
  - src/instr_decoder.sv
  - src/reg_status_table.sv
  - src/dispatch_stage.sv
  - src/dispatch_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/dispatch_tb.sv
